//--- acc_ctrl_if.sv
// Bank steering strobes from the bank controller to the accumulator banks
`timescale 1ns/1ps

interface acc_ctrl_if;

    // Bank currently accumulating, the other one is read
    logic active_bank;

    // Zero the active bank
    logic clr_en;

    // Add the partial-sum vector into the active bank
    logic add_en;

    // Capture one word from the inactive bank
    logic rd_en;

    // Controller side drives every strobe
    modport ctrl (
        output active_bank,
        output clr_en,
        output add_en,
        output rd_en
    );

    // Bank side only listens
    modport bank (
        input active_bank,
        input clr_en,
        input add_en,
        input rd_en
    );

endinterface

//--- acc_pkg.sv
// Shared widths, fixed-point constants, data types and controller states for the output accumulator
package acc_pkg;

    // ========================================================================
    // Widths and lane count
    // ========================================================================

    // Signed accumulator width, headroom for long K reductions
    localparam int ACC_W = 32;

    // Requantized output width
    localparam int OUT_W = 8;

    // Outputs packed per 64-bit DMA word
    localparam int LANES = 8;

    // ========================================================================
    // Fixed-point constants
    // ========================================================================

    // Scale factor is Q16.16, so 1.0 is 32'h0001_0000
    localparam int FRAC_BITS = 16;

    // INT8 saturation bounds
    localparam int Q8_MAX = 127;
    localparam int Q8_MIN = -128;

    // ========================================================================
    // Data types
    // ========================================================================

    // One accumulator entry
    typedef logic signed [ACC_W-1:0] acc_t;

    // One requantized output
    typedef logic signed [OUT_W-1:0] q8_t;

    // Unsigned Q16.16 scale
    typedef logic [31:0] scale_t;

    // Eight INT8 outputs, lane 0 in the low byte
    typedef logic [LANES*OUT_W-1:0] dma_word_t;

    // Eight accumulators of one DMA word, read stage 1 to stage 2
    typedef acc_t [LANES-1:0] acc_lanes_t;

    // Bank controller state
    typedef enum logic {
        IDLE,
        ACCUM
    } acc_state_e;

endpackage

//--- accum_banks.sv
// Two signed accumulator banks with clear, vector add and the first read stage
`timescale 1ns/1ps

module accum_banks
    import acc_pkg::*;
#(
    parameter int N_ROWS = 3,
    parameter int N_COLS = 4,
    parameter int ADDR_W = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    acc_ctrl_if.bank                      bank,
    input  acc_t [N_ROWS*N_COLS-1:0]      partial_sums,
    input  logic [ADDR_W-1:0]             rd_addr,
    output acc_lanes_t                    rd_lanes,
    output logic                          rd_valid
);

    // ========================================================================
    // Geometry
    // ========================================================================

    // Real accumulators, one per array output
    localparam int NUM_ACCS = N_ROWS * N_COLS;

    // Rounded up to whole DMA words
    localparam int BANK_DEPTH = ((NUM_ACCS + LANES - 1) / LANES) * LANES;

    // DMA words per bank
    localparam int N_WORDS = BANK_DEPTH / LANES;

    // Bank storage, entries past NUM_ACCS are padding and stay zero
    acc_t mem [2][BANK_DEPTH];

    // Read side always looks at the idle bank
    logic rd_bank;

    assign rd_bank = ~bank.active_bank;

    // ========================================================================
    // Accumulate and clear
    // ========================================================================

    // Add beats in while the tile runs
    // Add wins if a clear arrives on the same beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int b = 0; b < 2; b++) begin
                for (int i = 0; i < BANK_DEPTH; i++) begin
                    mem[b][i] <= '0;
                end
            end
        end else if (bank.add_en) begin
            for (int i = 0; i < NUM_ACCS; i++) begin
                mem[bank.active_bank][i] <= mem[bank.active_bank][i] + partial_sums[i];
            end
        end else if (bank.clr_en) begin
            // Only the active bank, the other may still be draining
            for (int i = 0; i < NUM_ACCS; i++) begin
                mem[bank.active_bank][i] <= '0;
            end
        end
    end

    // ========================================================================
    // Read stage 1
    // ========================================================================

    // Word w maps to accumulators 8w .. 8w+7
    always_ff @(posedge clk) begin
        if (bank.rd_en) begin
            for (int l = 0; l < LANES; l++) begin
                rd_lanes[l] <= mem[rd_bank][rd_addr * LANES + l];
            end
        end
    end

    // One-cycle marker for the requantizer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= bank.rd_en;
        end
    end

    // DMA address from the top must stay inside the bank
    a_rd_addr_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        bank.rd_en |-> (rd_addr < N_WORDS)
    );

endmodule

//--- bank_controller.sv
// Ping-pong bank controller owning the active bank, busy state and per-bank ready flags
`timescale 1ns/1ps

module bank_controller
    import acc_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      acc_clear,
    input  logic      acc_valid,
    input  logic      tile_done,
    input  logic      dma_rd_en,
    output logic      busy,
    output logic      bank_sel,
    output logic      dma_ready,
    acc_ctrl_if.ctrl  ctrl
);

    // ========================================================================
    // State
    // ========================================================================

    acc_state_e state_q;

    // Bank that takes partial sums
    logic active_q;

    // One ready flag per bank, set when its tile finishes
    logic [1:0] ready_q;

    // Tile start and end
    // tile_done has priority, it closes the tile
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else if (tile_done) begin
            state_q <= IDLE;
        end else if (acc_clear) begin
            state_q <= ACCUM;
        end
    end

    // Swap banks at the end of every tile
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_q <= 1'b0;
        end else if (tile_done) begin
            active_q <= ~active_q;
        end
    end

    // Ready flags
    // Finished bank becomes readable, first DMA read consumes the flag
    // Both events can land together but always on different banks
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready_q <= 2'b00;
        end else begin
            if (tile_done) begin
                ready_q[active_q] <= 1'b1;
            end
            if (dma_rd_en) begin
                ready_q[!active_q] <= 1'b0;
            end
        end
    end

    // ========================================================================
    // Outputs
    // ========================================================================

    assign busy      = (state_q == ACCUM);
    assign bank_sel  = active_q;

    // DMA always reads the bank that is not accumulating
    assign dma_ready = ready_q[!active_q];

    // Strobes pass straight through, the banks only see steered commands
    assign ctrl.active_bank = active_q;
    assign ctrl.clr_en      = acc_clear;
    assign ctrl.add_en      = acc_valid;
    assign ctrl.rd_en       = dma_rd_en;

    // Bank swap is caused only by the previous tile_done
    a_swap_on_done: assert property (
        @(posedge clk) disable iff (!rst_n)
        $changed(active_q) |-> $past(tile_done)
    );

endmodule

//--- flist.f
acc_pkg.sv
acc_ctrl_if.sv
bank_controller.sv
accum_banks.sv
requantizer.sv
output_accumulator.sv
tb_output_accumulator.sv

//--- output_accumulator.sv
// Top level of the double-buffered output accumulator, controller plus banks plus requantizer
`timescale 1ns/1ps

module output_accumulator
    import acc_pkg::*;
#(
    parameter int N_ROWS = 3,
    parameter int N_COLS = 4,
    parameter int ADDR_W = 4
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            acc_valid,
    input  logic                            acc_clear,
    input  logic                            tile_done,
    input  logic                            relu_en,
    input  scale_t                          scale_factor,
    input  logic [N_ROWS*N_COLS*ACC_W-1:0]  systolic_out,
    input  logic                            dma_rd_en,
    input  logic [ADDR_W-1:0]               dma_rd_addr,
    output dma_word_t                       dma_rd_data,
    output logic                            dma_ready,
    output logic                            busy,
    output logic                            bank_sel
);

    // ========================================================================
    // Internal links
    // ========================================================================

    // Steering strobes, controller to banks
    acc_ctrl_if ctrl_if ();

    // Stage 1 to stage 2 lanes
    acc_lanes_t rd_lanes;
    logic       rd_valid;

    // Bank selection and ready tracking
    bank_controller u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .acc_clear (acc_clear),
        .acc_valid (acc_valid),
        .tile_done (tile_done),
        .dma_rd_en (dma_rd_en),
        .busy      (busy),
        .bank_sel  (bank_sel),
        .dma_ready (dma_ready),
        .ctrl      (ctrl_if.ctrl)
    );

    // Storage and read stage 1
    accum_banks #(
        .N_ROWS (N_ROWS),
        .N_COLS (N_COLS),
        .ADDR_W (ADDR_W)
    ) u_banks (
        .clk          (clk),
        .rst_n        (rst_n),
        .bank         (ctrl_if.bank),
        .partial_sums (systolic_out),
        .rd_addr      (dma_rd_addr),
        .rd_lanes     (rd_lanes),
        .rd_valid     (rd_valid)
    );

    // Read stage 2, DMA data out
    requantizer u_requant (
        .clk          (clk),
        .rst_n        (rst_n),
        .relu_en      (relu_en),
        .scale_factor (scale_factor),
        .rd_lanes     (rd_lanes),
        .rd_valid     (rd_valid),
        .rd_data      (dma_rd_data)
    );

endmodule

//--- requantizer.sv
// Read stage 2 applying ReLU, Q16.16 scaling and INT8 saturation to eight lanes
`timescale 1ns/1ps

module requantizer
    import acc_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        relu_en,
    input  scale_t      scale_factor,
    input  acc_lanes_t  rd_lanes,
    input  logic        rd_valid,
    output dma_word_t   rd_data
);

    // ========================================================================
    // Per-lane conversion
    // ========================================================================

    // ReLU, then acc * scale >>> 16, then clamp to INT8
    function automatic q8_t quantize(input acc_t value, input scale_t scale, input logic relu);
        logic signed [63:0] relu_val;
        logic signed [63:0] scale_ext;
        logic signed [63:0] product;
        logic signed [63:0] shifted;
        q8_t                result;

        // Negative lanes drop to zero only when ReLU is on
        if (relu && (value < 0)) begin
            relu_val = '0;
        end else begin
            relu_val = 64'(value);
        end

        // Scale is unsigned, zero-extend before the signed multiply
        scale_ext = $signed({32'h0, scale});
        product   = relu_val * scale_ext;
        shifted   = product >>> FRAC_BITS;

        // Saturate
        if (shifted > Q8_MAX) begin
            result = q8_t'(Q8_MAX);
        end else if (shifted < Q8_MIN) begin
            result = q8_t'(Q8_MIN);
        end else begin
            result = shifted[OUT_W-1:0];
        end
        return result;
    endfunction

    // ========================================================================
    // Output register
    // ========================================================================

    // Lane 0 in the low byte, value held until the next read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (rd_valid) begin
            for (int l = 0; l < LANES; l++) begin
                rd_data[l*OUT_W +: OUT_W] <= quantize(rd_lanes[l], scale_factor, relu_en);
            end
        end
    end

    // Known data end to end, banks through requantizer
    a_rd_data_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(rd_data)
    );

endmodule

//--- tb_output_accumulator.sv
// Directed testbench for the output accumulator, run as the simulation top over the file list
`timescale 1ns/1ps

module tb_output_accumulator
    import acc_pkg::*;
;

    // ========================================================================
    // Geometry, constants and budget
    // ========================================================================

    localparam int N_ROWS   = 3;
    localparam int N_COLS   = 4;
    localparam int ADDR_W   = 4;
    localparam int NUM_ACCS = N_ROWS * N_COLS;
    localparam int DEPTH    = 16;

    localparam scale_t SCALE_ONE = 32'h0001_0000;

    // Cycle budget of each test and the summed watchdog total
    localparam int RESET_CYCLES    = 12;
    localparam int SINGLE_CYCLES   = 30;
    localparam int SCALE_CYCLES    = 30;
    localparam int PINGPONG_CYCLES = 30;
    localparam int PADDING_CYCLES  = 30;
    localparam int MARGIN_CYCLES   = 50;
    localparam int TOTAL_CYCLES    = RESET_CYCLES + SINGLE_CYCLES + SCALE_CYCLES
                                   + PINGPONG_CYCLES + PADDING_CYCLES + MARGIN_CYCLES;

    // ========================================================================
    // DUT signals
    // ========================================================================

    logic                        clk;
    logic                        rst_n;
    logic                        acc_valid;
    logic                        acc_clear;
    logic                        tile_done;
    logic                        relu_en;
    scale_t                      scale_factor;
    logic [NUM_ACCS*ACC_W-1:0]   systolic_out;
    logic                        dma_rd_en;
    logic [ADDR_W-1:0]           dma_rd_addr;
    dma_word_t                   dma_rd_data;
    logic                        dma_ready;
    logic                        busy;
    logic                        bank_sel;

    output_accumulator #(
        .N_ROWS (N_ROWS),
        .N_COLS (N_COLS),
        .ADDR_W (ADDR_W)
    ) uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .acc_valid    (acc_valid),
        .acc_clear    (acc_clear),
        .tile_done    (tile_done),
        .relu_en      (relu_en),
        .scale_factor (scale_factor),
        .systolic_out (systolic_out),
        .dma_rd_en    (dma_rd_en),
        .dma_rd_addr  (dma_rd_addr),
        .dma_rd_data  (dma_rd_data),
        .dma_ready    (dma_ready),
        .busy         (busy),
        .bank_sel     (bank_sel)
    );

    // 4 ns period
    always #2 clk = ~clk;

    // ========================================================================
    // Reference model state
    // ========================================================================

    // Shadow banks whose padding entries stay zero
    acc_t      shadow [2][DEPTH];
    logic      model_active;
    logic [15:0] lfsr_q;
    int error_count;
    int pass_count;
    int fail_count;

    // Galois LFSR stepped once per bit taken
    function automatic logic lfsr_bit();
        logic lsb;
        lsb = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (lsb) begin
            lfsr_q = lfsr_q ^ 16'hB400;
        end
        return lsb;
    endfunction

    function automatic logic [7:0] lfsr_byte();
        logic [7:0] b;
        for (int i = 0; i < 8; i++) begin
            b[i] = lfsr_bit();
        end
        return b;
    endfunction

    // Expected lane from ReLU and an unsigned Q16.16 multiply with floor shift and INT8 clamp
    function automatic q8_t ref_quant(input acc_t v, input scale_t s, input logic relu);
        longint base;
        longint res;
        base = (relu && v < 0) ? 64'sd0 : longint'(v);
        res  = (base * longint'({32'd0, s})) >>> FRAC_BITS;
        if (res > Q8_MAX) begin
            res = Q8_MAX;
        end else if (res < Q8_MIN) begin
            res = Q8_MIN;
        end
        return q8_t'(res);
    endfunction

    // Word w of bank b as the DMA should see it
    function automatic dma_word_t expect_word(input int b, input int w, input scale_t s,
                                              input logic relu);
        dma_word_t word;
        for (int l = 0; l < LANES; l++) begin
            word[l*OUT_W +: OUT_W] = ref_quant(shadow[b][w*LANES + l], s, relu);
        end
        return word;
    endfunction

    // ========================================================================
    // Compare tasks
    // ========================================================================

    task automatic check_word(input dma_word_t got, input dma_word_t exp, input string what);
        int lane;
        if (got !== exp) begin
            lane = 0;
            while (lane < LANES - 1 && got[lane*OUT_W +: OUT_W] === exp[lane*OUT_W +: OUT_W]) begin
                lane++;
            end
            $display("FAIL @%0t: %s got %h expected %h, first bad lane %0d",
                     $time, what, got, exp, lane);
            error_count++;
        end
    endtask

    task automatic check_lane(input q8_t got, input q8_t exp, input int lane, input string what);
        if (got !== exp) begin
            $display("FAIL @%0t: %s lane %0d got %0d expected %0d", $time, what, lane, got, exp);
            error_count++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAIL @%0t: %s got %b expected %b", $time, what, got, exp);
            error_count++;
        end
    endtask

    // ========================================================================
    // Drive helpers entered 1 ns after a rising edge
    // ========================================================================

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic end_strobes();
        acc_valid = 1'b0;
        acc_clear = 1'b0;
        tile_done = 1'b0;
        dma_rd_en = 1'b0;
    endtask

    task automatic start_tile();
        acc_clear = 1'b1;
        for (int i = 0; i < NUM_ACCS; i++) begin
            shadow[model_active][i] = '0;
        end
        step();
        end_strobes();
    endtask

    // Put one random vector on the bus and leave the clock edge to the caller
    task automatic load_beat();
        acc_t v;
        acc_valid = 1'b1;
        for (int i = 0; i < NUM_ACCS; i++) begin
            v = acc_t'($signed(lfsr_byte()));
            systolic_out[i*ACC_W +: ACC_W] = v;
            shadow[model_active][i] = shadow[model_active][i] + v;
        end
    endtask

    task automatic add_beat();
        load_beat();
        step();
        end_strobes();
    endtask

    task automatic finish_tile();
        tile_done = 1'b1;
        step();
        end_strobes();
        model_active = ~model_active;
    endtask

    // Sample 2 cycles after the read strobe
    task automatic read_word(input int w, input scale_t s, input logic relu,
                             output dma_word_t got);
        dma_rd_en    = 1'b1;
        dma_rd_addr  = ADDR_W'(w);
        scale_factor = s;
        relu_en      = relu;
        step();
        end_strobes();
        step();
        got = dma_rd_data;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (error_count == errs_before) begin
            pass_count++;
            $display("[%0t] %s: passed", $time, name);
        end else begin
            fail_count++;
            $display("[%0t] %s: %0d errors", $time, name, error_count - errs_before);
        end
    endtask

    // ========================================================================
    // Directed tests
    // ========================================================================

    task automatic reset_values();
        int errs;
        dma_word_t got;
        errs = error_count;
        check_flag(busy, 1'b0, "busy after reset");
        check_flag(bank_sel, 1'b0, "bank_sel after reset");
        check_flag(dma_ready, 1'b0, "dma_ready after reset");
        read_word(0, SCALE_ONE, 1'b0, got);
        check_word(got, '0, "word 0 before any tile");
        finish_test("reset_values", errs);
    endtask

    task automatic single_tile();
        int errs;
        dma_word_t got;
        errs = error_count;
        start_tile();
        check_flag(busy, 1'b1, "busy after clear");
        repeat (5) add_beat();
        check_flag(busy, 1'b1, "busy during tile");
        finish_tile();
        check_flag(busy, 1'b0, "busy after tile_done");
        check_flag(bank_sel, 1'b1, "bank_sel after tile_done");
        check_flag(dma_ready, 1'b1, "dma_ready after tile_done");
        for (int w = 0; w < 2; w++) begin
            read_word(w, SCALE_ONE, 1'b0, got);
            check_word(got, expect_word(0, w, SCALE_ONE, 1'b0), "tile 1 at scale 1.0");
            // First read consumes the ready flag
            check_flag(dma_ready, 1'b0, "dma_ready after read");
        end
        finish_test("single_tile", errs);
    endtask

    task automatic relu_and_scaling();
        int errs;
        dma_word_t got;
        scale_t scales [4];
        logic relus [4];
        errs = error_count;
        scales = '{32'h0000_8000, 32'h0000_8000, 32'h0004_0000, 32'h8001_0000};
        relus  = '{1'b0, 1'b1, 1'b0, 1'b0};
        for (int k = 0; k < 4; k++) begin
            for (int w = 0; w < 2; w++) begin
                read_word(w, scales[k], relus[k], got);
                check_word(got, expect_word(0, w, scales[k], relus[k]), "scaled read");
            end
        end
        finish_test("relu_and_scaling", errs);
    endtask

    task automatic ping_pong();
        int errs;
        dma_word_t got;
        dma_word_t got_next;
        errs = error_count;
        start_tile();
        // Reads of bank 0 share cycles with beats into bank 1
        for (int k = 0; k < 4; k++) begin
            load_beat();
            read_word(k % 2, SCALE_ONE, 1'b0, got);
            check_word(got, expect_word(0, k % 2, SCALE_ONE, 1'b0),
                       "held bank during new tile");
        end
        add_beat();
        check_flag(busy, 1'b1, "busy in second tile");
        finish_tile();
        check_flag(bank_sel, 1'b0, "bank_sel after second tile");
        check_flag(dma_ready, 1'b1, "dma_ready after second tile");
        // Back-to-back reads with two in flight
        dma_rd_en   = 1'b1;
        dma_rd_addr = 0;
        step();
        dma_rd_addr = 1;
        step();
        dma_rd_en = 1'b0;
        got = dma_rd_data;
        step();
        got_next = dma_rd_data;
        check_word(got, expect_word(1, 0, SCALE_ONE, 1'b0), "back-to-back word 0");
        check_word(got_next, expect_word(1, 1, SCALE_ONE, 1'b0), "back-to-back word 1");
        finish_test("ping_pong", errs);
    endtask

    task automatic padding_and_clear();
        int errs;
        dma_word_t got;
        errs = error_count;
        // Bank 0 still holds tile 1 and the clear must wipe it
        start_tile();
        add_beat();
        finish_tile();
        for (int w = 0; w < 2; w++) begin
            read_word(w, SCALE_ONE, 1'b0, got);
            check_word(got, expect_word(0, w, SCALE_ONE, 1'b0), "single beat after clear");
        end
        // Padding lanes stay zero even with a huge scale
        read_word(1, 32'h8001_0000, 1'b0, got);
        for (int l = 4; l < LANES; l++) begin
            check_lane(q8_t'(got[l*OUT_W +: OUT_W]), q8_t'(0), l, "padding");
        end
        finish_test("padding_and_clear", errs);
    endtask

    // ========================================================================
    // Main sequence and watchdog
    // ========================================================================

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        acc_valid    = 1'b0;
        acc_clear    = 1'b0;
        tile_done    = 1'b0;
        relu_en      = 1'b0;
        scale_factor = SCALE_ONE;
        systolic_out = '0;
        dma_rd_en    = 1'b0;
        dma_rd_addr  = '0;
        lfsr_q       = 16'd13117;
        model_active = 1'b0;
        error_count  = 0;
        pass_count   = 0;
        fail_count   = 0;
        for (int b = 0; b < 2; b++) begin
            for (int i = 0; i < DEPTH; i++) begin
                shadow[b][i] = '0;
            end
        end
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        reset_values();
        single_tile();
        relu_and_scaling();
        ping_pong();
        padding_and_clear();

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(TOTAL_CYCLES * 4);
        $display("Watchdog: simulation ran past its cycle budget and was stopped");
        $display("TEST FAILED");
        $finish;
    end

endmodule
